// File: Makefile
# Verilator build and run of the cpu testbench

SOURCES := cpu.f include/cpu_config.svh $(wildcard source/*.sv) test/cpu_tb.sv

obj_dir/Vcpu_tb: $(SOURCES)
	verilator --binary --timing --top-module cpu_tb -f cpu.f -o Vcpu_tb

run: obj_dir/Vcpu_tb
	./obj_dir/Vcpu_tb | tee sim.log
	grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: cpu.f
+incdir+include
source/isa_pkg.sv
source/bus_pkg.sv
source/fetch.sv
source/request_fifo.sv
source/memory.sv
source/mmu.sv
source/peripheral_manager.sv
source/cpu.sv
test/cpu_tb.sv

// File: include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath widths
`define CPU_DATA_WIDTH 32
`define CPU_ADDR_WIDTH 8

// Data RAM fills the lower half of the address space
`define CPU_RAM_DEPTH 128

// Entries in the request queue
`define CPU_FIFO_DEPTH 4

// Peripheral registers sit above the RAM
`define CPU_PWM_ADDR 8'h80   // PWM duty
`define CPU_BTN_ADDR 8'h81   // Button status

// Width of the PWM duty register and counter
`define CPU_PWM_WIDTH 8

`endif

// File: source/bus_pkg.sv
`include "cpu_config.svh"

package bus_pkg;

    // One queued memory access
    typedef struct packed {
        logic                       write;
        logic [`CPU_ADDR_WIDTH-1:0] addr;
        logic [`CPU_DATA_WIDTH-1:0] wdata;
    } mem_req_t;

    // Address bit 7 picks the region
    typedef enum logic {
        REGION_RAM    = 1'b0,
        REGION_PERIPH = 1'b1
    } region_t;

    function automatic region_t region_of(input logic [`CPU_ADDR_WIDTH-1:0] addr);
        return region_t'(addr[`CPU_ADDR_WIDTH-1]);
    endfunction

endpackage

// File: source/cpu.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu
    import isa_pkg::*;
    import bus_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       enable,
    input  logic                       btn1,
    input  logic                       btn2,
    input  instr_t                     rom_data,
    output logic [`CPU_ADDR_WIDTH-1:0] rom_address,
    output logic [5:0]                 led,
    output logic                       port_pwm1,
    output logic                       load_valid,
    output logic [`CPU_DATA_WIDTH-1:0] load_data
);
    // Fetch to queue
    logic     in_req, in_ack;
    mem_req_t in_payload;

    // Queue to memory stage
    logic     out_req, out_ack;
    mem_req_t out_payload;

    // Memory stage to MMU
    logic                       mem_valid, mem_write, mem_done;
    logic [`CPU_ADDR_WIDTH-1:0] mem_addr;
    logic [`CPU_DATA_WIDTH-1:0] mem_wdata, mem_rdata;

    // MMU to peripherals
    logic                       p_write;
    logic [`CPU_ADDR_WIDTH-1:0] p_addr;
    logic [`CPU_DATA_WIDTH-1:0] p_wdata, p_rdata;

    fetch fetch_i (
        .clk(clock), .reset(reset), .enable(enable),
        .rom_data(rom_data), .rom_address(rom_address),
        .in_req(in_req), .in_ack(in_ack), .in_payload(in_payload)
    );

    request_fifo request_fifo_i (
        .clk(clock), .reset(reset),
        .in_req(in_req), .in_ack(in_ack), .in_payload(in_payload),
        .out_req(out_req), .out_ack(out_ack), .out_payload(out_payload)
    );

    memory memory_i (
        .clk(clock), .reset(reset),
        .out_req(out_req), .out_ack(out_ack), .out_payload(out_payload),
        .mem_valid(mem_valid), .mem_write(mem_write), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_done(mem_done),
        .load_valid(load_valid), .load_data(load_data), .led(led)
    );

    mmu mmu_i (
        .clk(clock), .reset(reset),
        .mem_valid(mem_valid), .mem_write(mem_write), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_done(mem_done),
        .p_write(p_write), .p_addr(p_addr), .p_wdata(p_wdata), .p_rdata(p_rdata)
    );

    peripheral_manager peripheral_manager_i (
        .clk(clock), .reset(reset),
        .p_write(p_write), .p_addr(p_addr), .p_wdata(p_wdata), .p_rdata(p_rdata),
        .btn1(btn1), .btn2(btn2), .pwm_out(port_pwm1)
    );

endmodule

// File: source/fetch.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetch
    import isa_pkg::*;
    import bus_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       enable,
    input  instr_t                     rom_data,
    output logic [`CPU_ADDR_WIDTH-1:0] rom_address,
    output logic                       in_req,
    input  logic                       in_ack,
    output mem_req_t                   in_payload
);
    typedef enum logic [2:0] {
        S_READ,
        S_REQUEST,
        S_ACK_HIGH,
        S_ACK_LOW,
        S_HALTED
    } state_t;

    state_t                     state;
    logic [`CPU_ADDR_WIDTH-1:0] pc;
    instr_t                     instr_q;   // Registered ROM word

    assign rom_address = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= S_READ;
            pc     <= '0;
            in_req <= 1'b0;
        end else if (enable) begin
            case (state)
                S_READ: state <= S_REQUEST;
                S_REQUEST: begin
                    case (instr_q.op)
                        OP_STORE, OP_LOAD: begin
                            in_req <= 1'b1;
                            state  <= S_ACK_HIGH;
                        end
                        OP_HALT: state <= S_HALTED;   // Stays here until reset
                        default: begin
                            pc    <= pc + 1'b1;       // Nop skips the queue
                            state <= S_READ;
                        end
                    endcase
                end
                S_ACK_HIGH: begin
                    if (in_ack) begin
                        in_req <= 1'b0;
                        state  <= S_ACK_LOW;
                    end
                end
                S_ACK_LOW: begin
                    if (!in_ack) begin
                        pc    <= pc + 1'b1;
                        state <= S_READ;
                    end
                end
                default: state <= S_HALTED;
            endcase
        end
    end

    // Word and payload registers
    always_ff @(posedge clk) begin
        if (enable && state == S_READ)
            instr_q <= rom_data;
        if (enable && state == S_REQUEST) begin
            in_payload.write <= (instr_q.op == OP_STORE);
            in_payload.addr  <= instr_q.addr;
            in_payload.wdata <= {{(`CPU_DATA_WIDTH-16){1'b0}}, instr_q.imm};
        end
    end

endmodule

// File: source/isa_pkg.sv
`include "cpu_config.svh"

package isa_pkg;

    // Memory operations carried in the top two bits
    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_STORE = 2'd1,
        OP_LOAD  = 2'd2,
        OP_HALT  = 2'd3
    } mem_op_t;

    // Instruction word as read from the ROM
    typedef struct packed {
        mem_op_t                    op;      // Bits 31:30
        logic [`CPU_ADDR_WIDTH-1:0] addr;    // Bits 29:22
        logic [5:0]                 unused;
        logic [15:0]                imm;     // Store data, zero-extended
    } instr_t;

endpackage

// File: source/memory.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module memory
    import bus_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       out_req,
    output logic                       out_ack,
    input  mem_req_t                   out_payload,
    output logic                       mem_valid,
    output logic                       mem_write,
    output logic [`CPU_ADDR_WIDTH-1:0] mem_addr,
    output logic [`CPU_DATA_WIDTH-1:0] mem_wdata,
    input  logic [`CPU_DATA_WIDTH-1:0] mem_rdata,
    input  logic                       mem_done,
    output logic                       load_valid,
    output logic [`CPU_DATA_WIDTH-1:0] load_data,
    output logic [5:0]                 led
);
    typedef enum logic [1:0] {M_IDLE, M_WAIT, M_RELEASE} state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= M_IDLE;
            out_ack    <= 1'b0;
            mem_valid  <= 1'b0;
            load_valid <= 1'b0;
            led        <= '1;           // LEDs are active low
        end else begin
            mem_valid  <= 1'b0;
            load_valid <= 1'b0;
            case (state)
                M_IDLE: if (out_req) begin
                    mem_valid <= 1'b1;  // Single cycle strobe
                    state     <= M_WAIT;
                end
                M_WAIT: if (mem_done) begin
                    out_ack <= 1'b1;
                    if (!mem_write) begin
                        load_valid <= 1'b1;
                        led        <= ~mem_rdata[5:0];
                    end
                    state <= M_RELEASE;
                end
                default: if (!out_req) begin
                    out_ack <= 1'b0;
                    state   <= M_IDLE;
                end
            endcase
        end
    end

    // Request fields and load result
    always_ff @(posedge clk) begin
        if (state == M_IDLE && out_req) begin
            mem_write <= out_payload.write;
            mem_addr  <= out_payload.addr;
            mem_wdata <= out_payload.wdata;
        end
        if (state == M_WAIT && mem_done && !mem_write)
            load_data <= mem_rdata;
    end

endmodule

// File: source/mmu.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module mmu
    import bus_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       mem_valid,
    input  logic                       mem_write,
    input  logic [`CPU_ADDR_WIDTH-1:0] mem_addr,
    input  logic [`CPU_DATA_WIDTH-1:0] mem_wdata,
    output logic [`CPU_DATA_WIDTH-1:0] mem_rdata,
    output logic                       mem_done,
    output logic                       p_write,
    output logic [`CPU_ADDR_WIDTH-1:0] p_addr,
    output logic [`CPU_DATA_WIDTH-1:0] p_wdata,
    input  logic [`CPU_DATA_WIDTH-1:0] p_rdata
);
    localparam int RAM_AW = $clog2(`CPU_RAM_DEPTH);

    logic [`CPU_DATA_WIDTH-1:0] ram [`CPU_RAM_DEPTH];
    region_t                    region;
    logic [RAM_AW-1:0]          ram_index;

    assign region    = region_of(mem_addr);
    assign ram_index = mem_addr[RAM_AW-1:0];

    // Peripheral side sees the request directly
    assign p_write = mem_valid && mem_write && (region == REGION_PERIPH);
    assign p_addr  = mem_addr;
    assign p_wdata = mem_wdata;

    always_ff @(posedge clk) begin
        if (mem_valid && mem_write && region == REGION_RAM)
            ram[ram_index] <= mem_wdata;
        if (mem_valid && !mem_write)
            mem_rdata <= (region == REGION_RAM) ? ram[ram_index] : p_rdata;
    end

    always_ff @(posedge clk) begin
        if (reset)
            mem_done <= 1'b0;
        else
            mem_done <= mem_valid;   // Fixed one cycle latency
    end

endmodule

// File: source/peripheral_manager.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module peripheral_manager (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       p_write,
    input  logic [`CPU_ADDR_WIDTH-1:0] p_addr,
    input  logic [`CPU_DATA_WIDTH-1:0] p_wdata,
    output logic [`CPU_DATA_WIDTH-1:0] p_rdata,
    input  logic                       btn1,
    input  logic                       btn2,
    output logic                       pwm_out
);
    logic [`CPU_PWM_WIDTH-1:0] duty;
    logic [`CPU_PWM_WIDTH-1:0] pwm_count;   // Free running
    logic [1:0]                btn_meta;
    logic [1:0]                btn_status;  // {btn2, btn1} after sync

    always_ff @(posedge clk) begin
        if (reset) begin
            duty       <= '0;
            pwm_count  <= '0;
            pwm_out    <= 1'b0;
            btn_meta   <= '0;
            btn_status <= '0;
        end else begin
            if (p_write && p_addr == `CPU_PWM_ADDR)
                duty <= p_wdata[`CPU_PWM_WIDTH-1:0];
            pwm_count <= pwm_count + 1'b1;
            pwm_out   <= (pwm_count < duty);   // High for duty counts per period
            btn_meta   <= {btn2, btn1};
            btn_status <= btn_meta;
        end
    end

    // Read mux
    always_comb begin
        case (p_addr)
            `CPU_PWM_ADDR: p_rdata = {{(`CPU_DATA_WIDTH-`CPU_PWM_WIDTH){1'b0}}, duty};
            `CPU_BTN_ADDR: p_rdata = {{(`CPU_DATA_WIDTH-2){1'b0}}, btn_status};
            default:       p_rdata = '0;
        endcase
    end

endmodule

// File: source/request_fifo.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module request_fifo
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     in_req,
    output logic     in_ack,
    input  mem_req_t in_payload,
    output logic     out_req,
    input  logic     out_ack,
    output mem_req_t out_payload
);
    localparam int unsigned DEPTH = `CPU_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    typedef enum logic [1:0] {O_IDLE, O_REQ, O_RELEASE} out_state_t;

    mem_req_t   entries [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    out_state_t       out_state;
    logic             push;
    logic             pop;

    // Accept only while there is room
    assign push = in_req && !in_ack && (count != (PTR_W+1)'(DEPTH));
    assign pop  = (out_state == O_RELEASE) && !out_ack;   // Ack has fallen

    assign out_payload = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (push)
            entries[wr_ptr] <= in_payload;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            in_ack    <= 1'b0;
            out_req   <= 1'b0;
            out_state <= O_IDLE;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
        end else begin
            // Input side
            if (push) begin
                in_ack <= 1'b1;
                wr_ptr <= wr_ptr + 1'b1;
            end else if (in_ack && !in_req) begin
                in_ack <= 1'b0;
            end

            // Output side
            case (out_state)
                O_IDLE: if (count != '0) begin
                    out_req   <= 1'b1;
                    out_state <= O_REQ;
                end
                O_REQ: if (out_ack) begin
                    out_req   <= 1'b0;
                    out_state <= O_RELEASE;
                end
                default: if (pop) begin
                    rd_ptr    <= rd_ptr + 1'b1;
                    out_state <= O_IDLE;
                end
            endcase

            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

// File: test/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb
    import isa_pkg::*;
;
    localparam int BURST_LEN  = 40;   // Store burst long enough to fill the queue
    localparam int RANDOM_LEN = 48;
    localparam int PROG_LEN   = BURST_LEN + RANDOM_LEN + 4;
    localparam int HALT_ADDR  = PROG_LEN - 1;

    logic                       clock;
    logic                       reset;
    logic                       enable;
    logic                       btn1;
    logic                       btn2;
    instr_t                     rom_data;
    logic [`CPU_ADDR_WIDTH-1:0] rom_address;
    logic [5:0]                 led;
    logic                       port_pwm1;
    logic                       load_valid;
    logic [`CPU_DATA_WIDTH-1:0] load_data;

    instr_t     rom [256];
    integer     seed = 32'hda4d;
    logic [7:0] duty;
    int         total_loads = 0;
    int         load_count = 0;
    int         load_errors = 0;
    int         led_errors = 0;
    int         pwm_errors = 0;
    int         other_errors = 0;

    cpu cpu_i (
        .clock(clock), .reset(reset), .enable(enable), .btn1(btn1), .btn2(btn2),
        .rom_data(rom_data), .rom_address(rom_address), .led(led),
        .port_pwm1(port_pwm1), .load_valid(load_valid), .load_data(load_data)
    );

    assign rom_data = rom[rom_address];   // Asynchronous ROM

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic instr_t make_instr(input mem_op_t op, input logic [7:0] addr,
                                          input logic [15:0] imm);
        instr_t word;
        word.op     = op;
        word.addr   = addr;
        word.unused = '0;
        word.imm    = imm;
        return word;
    endfunction

    task automatic build_program();
        logic [31:0] rnd;
        mem_op_t     op;
        // Unused words halt, tagged with their own address
        for (int i = 0; i < 256; i++)
            rom[i] = make_instr(OP_HALT, 8'(i), {8'h0, 8'(i)});
        for (int i = 0; i < BURST_LEN + RANDOM_LEN; i++) begin
            rnd = $random(seed);
            case (rnd[31:30])
                2'd0:    op = OP_NOP;
                2'd2:    op = OP_LOAD;
                default: op = OP_STORE;
            endcase
            if (i < BURST_LEN)
                op = OP_STORE;
            if (op == OP_LOAD)
                total_loads++;
            rom[i] = make_instr(op, {3'b000, rnd[20:16]}, rnd[15:0]);   // Small address range
        end
        rnd  = $random(seed);
        duty = rnd[7:0];
        if (duty == 8'h00 || duty == 8'hff)
            duty = 8'h5a;
        rom[PROG_LEN-4] = make_instr(OP_STORE, `CPU_PWM_ADDR, {8'h0, duty});
        rom[PROG_LEN-3] = make_instr(OP_LOAD, `CPU_PWM_ADDR, 16'h0);
        rom[PROG_LEN-2] = make_instr(OP_LOAD, `CPU_BTN_ADDR, 16'h0);
        rom[HALT_ADDR]  = make_instr(OP_HALT, 8'h0, 16'h0);
        total_loads += 2;
    endtask

    // Replays the program and returns the value of load number n
    function automatic logic [31:0] reference_load(input int n, output bit known);
        logic [31:0] shadow [`CPU_RAM_DEPTH];
        bit          written [`CPU_RAM_DEPTH];
        logic [7:0]  pwm_duty;
        int          loads;
        instr_t      word;
        pwm_duty = 8'h0;
        loads    = 0;
        known    = 1'b0;
        foreach (written[i])
            written[i] = 1'b0;
        for (int pc = 0; pc < PROG_LEN; pc++) begin
            word = rom[pc];
            if (word.op == OP_HALT)
                break;
            if (word.op == OP_STORE) begin
                if (!word.addr[7]) begin
                    shadow[word.addr[6:0]]  = {16'h0, word.imm};
                    written[word.addr[6:0]] = 1'b1;
                end else if (word.addr == `CPU_PWM_ADDR) begin
                    pwm_duty = word.imm[7:0];
                end
            end else if (word.op == OP_LOAD) begin
                if (loads == n) begin
                    known = 1'b1;
                    if (!word.addr[7]) begin
                        known = written[word.addr[6:0]];
                        return known ? shadow[word.addr[6:0]] : 32'h0;
                    end
                    if (word.addr == `CPU_PWM_ADDR)
                        return {24'h0, pwm_duty};
                    if (word.addr == `CPU_BTN_ADDR)
                        return {30'h0, btn2, btn1};
                    return 32'h0;   // Unmapped peripheral
                end
                loads++;
            end
        end
        return 32'h0;
    endfunction

    task automatic check_load(input int idx, input logic [`CPU_DATA_WIDTH-1:0] actual,
                              input logic [`CPU_DATA_WIDTH-1:0] expected);
        if (actual !== expected) begin
            load_errors++;
            $display("Error at %0t ns: load %0d returned %h, expected %h",
                     $time, idx, actual, expected);
        end
    endtask

    task automatic check_led(input logic [5:0] actual, input logic [5:0] expected);
        if (actual !== expected) begin
            led_errors++;
            $display("Error at %0t ns: led is %b, expected %b", $time, actual, expected);
        end
    endtask

    task automatic check_pwm(input logic [`CPU_PWM_WIDTH:0] actual,
                             input logic [`CPU_PWM_WIDTH:0] expected);
        if (actual !== expected) begin
            pwm_errors++;
            $display("Error at %0t ns: pwm high for %0d of 256 cycles, expected %0d",
                     $time, actual, expected);
        end
    endtask

    // Load results, sampled away from the active edge
    always @(negedge clock) begin
        logic [31:0] expected;
        bit          known;
        if (!reset && load_valid) begin
            if (load_count >= total_loads) begin
                other_errors++;
                $display("A load result appeared after the last load of the program");
            end
            expected = reference_load(load_count, known);
            if (known) begin
                check_load(load_count, load_data, expected);
                check_led(led, ~expected[5:0]);
            end else begin
                $display("Load %0d reads a never stored address, value unknown", load_count);
                check_led(led, ~load_data[5:0]);
            end
            load_count++;
        end
    end

    initial begin
        repeat (PROG_LEN * 40 + 2000) @(posedge clock);
        $display("Timeout: the program did not finish in %0d cycles", PROG_LEN * 40 + 2000);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [`CPU_PWM_WIDTH:0]    high;
        logic [`CPU_ADDR_WIDTH-1:0] halt_pc;
        reset  = 1'b1;
        enable = 1'b0;
        btn1   = 1'b0;
        btn2   = 1'b0;
        build_program();
        repeat (10) @(posedge clock);
        #10;
        check_led(led, 6'h3f);          // All off out of reset
        reset  = 1'b0;
        enable = 1'b1;
        btn1   = 1'b1;
        btn2   = 1'b0;

        wait (load_count == total_loads);
        wait (rom_address == HALT_ADDR);
        repeat (4) @(posedge clock);
        halt_pc = rom_address;

        // Two full PWM periods
        for (int w = 0; w < 2; w++) begin
            high = '0;
            repeat (256) begin
                @(negedge clock);
                if (port_pwm1)
                    high++;
            end
            check_pwm(high, {1'b0, duty});
        end

        if (rom_address !== halt_pc || halt_pc != HALT_ADDR) begin
            other_errors++;
            $display("The program counter moved after the halt word");
        end
        if (load_count != total_loads) begin
            other_errors++;
            $display("Saw %0d load results, the program has %0d", load_count, total_loads);
        end

        $display("Errors: load %0d, led %0d, pwm %0d, other %0d",
                 load_errors, led_errors, pwm_errors, other_errors);
        if (load_errors + led_errors + pwm_errors + other_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule
